//--- design/anim_pkg.sv
package anim_pkg;

	typedef enum logic [2:0] {
		pose_stand,
		pose_attack,
		pose_move_l,
		pose_move_r,
		pose_defense,
		pose_hurt
	} pose_e;

	typedef struct packed {
		logic move_r;
		logic move_l;
		logic attack;
		logic defense;
		logic hurt;
	} cmd_t;

	typedef struct packed {
		logic tick;
		logic wrap;
	} seq_status_t;

	// extra strobes each frame is held
	function automatic logic [7:0] pose_delay(pose_e p);
		case (p)
			pose_attack: return 8'd3;
			default:     return 8'd10;
		endcase
	endfunction

	function automatic logic [7:0] pose_last_frame(pose_e p);
		case (p)
			pose_attack:  return 8'd5;
			pose_move_l:  return 8'd9;
			pose_move_r:  return 8'd8;
			pose_defense: return 8'd0;
			pose_hurt:    return 8'd4;
			default:      return 8'd7;
		endcase
	endfunction

	// one-shot poses play once and fall back to stand
	function automatic logic is_one_shot(pose_e p);
		return (p == pose_attack) || (p == pose_defense) || (p == pose_hurt);
	endfunction

endpackage

//--- design/sprite_pkg.sv
package sprite_pkg;

	import anim_pkg::*;

	localparam int ADDR_W = 12;
	localparam int X_W = 10;

	typedef struct packed {
		pose_e               pose;
		logic [7:0]          frame;
		logic [ADDR_W-1:0]   addr;
		logic [X_W-1:0]      x;
	} sprite_desc_t;

	// frame strips sit 16 entries apart, in pose order
	function automatic logic [ADDR_W-1:0] sprite_base(pose_e p);
		logic [ADDR_W-1:0] idx;
		idx = ADDR_W'(p);
		return idx << 4;
	endfunction

endpackage

//--- design/anim_fsm.sv
`timescale 1ns/1ps

module anim_fsm
	import anim_pkg::*;
(
	input  logic        Clk,
	input  logic        rst_n,
	input  cmd_t        cmd,
	input  seq_status_t status,
	output pose_e       pose,
	output logic        restart
);

	pose_e next_pose;

	always_comb
	begin
		next_pose = pose;
		if (status.tick)
		begin
			case (pose)
				pose_stand:
				begin
					if (cmd.attack)
						next_pose = pose_attack;
					else if (cmd.move_r)
						next_pose = pose_move_r;
					else if (cmd.move_l)
						next_pose = pose_move_l;
					else if (cmd.defense)
						next_pose = pose_defense;
					else if (cmd.hurt)
						next_pose = pose_hurt;
				end
				pose_move_r:
				begin
					// holding the walk key keeps walking
					if (cmd.move_r)
						next_pose = pose_move_r;
					else if (cmd.attack)
						next_pose = pose_attack;
					else if (cmd.move_l)
						next_pose = pose_move_l;
					else if (cmd.defense)
						next_pose = pose_defense;
					else if (cmd.hurt)
						next_pose = pose_hurt;
					else
						next_pose = pose_stand;
				end
				pose_move_l:
				begin
					if (cmd.move_l)
						next_pose = pose_move_l;
					else if (cmd.attack)
						next_pose = pose_attack;
					else if (cmd.move_r)
						next_pose = pose_move_r;
					else if (cmd.defense)
						next_pose = pose_defense;
					else if (cmd.hurt)
						next_pose = pose_hurt;
					else
						next_pose = pose_stand;
				end
				default:
				begin
					// one-shot: commands ignored until the strip finishes
					if (is_one_shot(pose) && status.wrap)
						next_pose = pose_stand;
				end
			endcase
		end
	end

	assign restart = status.tick && (next_pose != pose);

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			pose <= pose_stand;
		else
			pose <= next_pose;
	end

endmodule

//--- design/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer
	import anim_pkg::*;
(
	input  logic        Clk,
	input  logic        rst_n,
	input  logic        frame_clk,
	input  pose_e       pose,
	input  logic        restart,
	output seq_status_t status,
	output logic [7:0]  frame
);

	logic       frame_clk_q;
	logic       frame_clk_qq;
	logic       tick_q;
	logic [7:0] delay;
	logic       delay_done;
	logic       frame_last;

	// register the strobe, then detect its rising edge
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			frame_clk_q <= 1'b0;
			frame_clk_qq <= 1'b0;
			tick_q <= 1'b0;
		end
		else
		begin
			frame_clk_q <= frame_clk;
			frame_clk_qq <= frame_clk_q;
			tick_q <= frame_clk_q && !frame_clk_qq;
		end
	end

	assign delay_done = (delay >= pose_delay(pose));
	assign frame_last = (frame >= pose_last_frame(pose));

	assign status.tick = tick_q;
	assign status.wrap = delay_done && frame_last;

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			delay <= 8'd0;
			frame <= 8'd0;
		end
		else if (tick_q)
		begin
			if (restart)
			begin
				delay <= 8'd0;
				frame <= 8'd0;
			end
			else if (!delay_done)
				delay <= delay + 8'd1;
			else
			begin
				delay <= 8'd0;
				frame <= frame_last ? 8'd0 : frame + 8'd1;
			end
		end
	end

endmodule

//--- design/position_tracker.sv
`timescale 1ns/1ps

module position_tracker
	import anim_pkg::*;
	import sprite_pkg::*;
#(
	parameter logic [X_W-1:0] X_MIN   = X_W'(0),
	parameter logic [X_W-1:0] X_MAX   = X_W'(600),
	parameter logic [X_W-1:0] X_START = X_W'(300),
	parameter logic [X_W-1:0] STEP    = X_W'(4)
)
(
	input  logic           Clk,
	input  logic           rst_n,
	input  logic           tick,
	input  pose_e          pose,
	output logic [X_W-1:0] x
);

	logic [X_W:0]   step_up;
	logic [X_W:0]   floor_lim;
	logic [X_W-1:0] x_next;

	// one extra bit so the bound checks cannot wrap
	assign step_up = {1'b0, x} + {1'b0, STEP};
	assign floor_lim = {1'b0, X_MIN} + {1'b0, STEP};

	always_comb
	begin
		x_next = x;
		case (pose)
			pose_move_r:
				x_next = (step_up > {1'b0, X_MAX}) ? X_MAX : step_up[X_W-1:0];
			pose_move_l:
				x_next = ({1'b0, x} < floor_lim) ? X_MIN : x - STEP;
			default:
				x_next = x;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			x <= X_START;
		else if (tick)
			x <= x_next;
	end

endmodule

//--- design/sprite_output.sv
`timescale 1ns/1ps

module sprite_output
	import anim_pkg::*;
	import sprite_pkg::*;
(
	input  logic           Clk,
	input  logic           rst_n,
	input  logic           tick,
	input  pose_e          pose,
	input  logic [7:0]     frame,
	input  logic [X_W-1:0] x,
	output sprite_desc_t   sprite_desc,
	output logic           sprite_valid,
	input  logic           sprite_ready
);

	logic              capture;
	logic [ADDR_W-1:0] addr;

	assign addr = sprite_base(pose) + ADDR_W'(frame);

	// pose, frame and x settle one cycle after the tick
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			capture <= 1'b0;
		else
			capture <= tick;
	end

	always_ff @(posedge Clk)
	begin
		if (capture)
		begin
			sprite_desc.pose <= pose;
			sprite_desc.frame <= frame;
			sprite_desc.addr <= addr;
			sprite_desc.x <= x;
		end
	end

	// latest wins, an unaccepted descriptor is overwritten
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			sprite_valid <= 1'b0;
		else if (capture)
			sprite_valid <= 1'b1;
		else if (sprite_ready)
			sprite_valid <= 1'b0;
	end

endmodule

//--- design/fighter_anim_top.sv
`timescale 1ns/1ps

module fighter_anim_top
	import anim_pkg::*;
	import sprite_pkg::*;
(
	input  logic         Clk,
	input  logic         rst_n,
	input  logic         frame_clk,
	input  cmd_t         cmd,
	output sprite_desc_t sprite_desc,
	output logic         sprite_valid,
	input  logic         sprite_ready
);

	// arena bounds and walk speed
	localparam logic [X_W-1:0] X_MIN   = X_W'(0);
	localparam logic [X_W-1:0] X_MAX   = X_W'(600);
	localparam logic [X_W-1:0] X_START = X_W'(300);
	localparam logic [X_W-1:0] STEP    = X_W'(4);

	pose_e          pose;
	logic           restart;
	seq_status_t    status;
	logic [7:0]     frame;
	logic [X_W-1:0] x;

	anim_fsm i_anim_fsm (
		.Clk     (Clk),
		.rst_n   (rst_n),
		.cmd     (cmd),
		.status  (status),
		.pose    (pose),
		.restart (restart)
	);

	frame_sequencer i_frame_sequencer (
		.Clk       (Clk),
		.rst_n     (rst_n),
		.frame_clk (frame_clk),
		.pose      (pose),
		.restart   (restart),
		.status    (status),
		.frame     (frame)
	);

	position_tracker #(
		.X_MIN   (X_MIN),
		.X_MAX   (X_MAX),
		.X_START (X_START),
		.STEP    (STEP)
	) i_position_tracker (
		.Clk   (Clk),
		.rst_n (rst_n),
		.tick  (status.tick),
		.pose  (pose),
		.x     (x)
	);

	sprite_output i_sprite_output (
		.Clk          (Clk),
		.rst_n        (rst_n),
		.tick         (status.tick),
		.pose         (pose),
		.frame        (frame),
		.x            (x),
		.sprite_desc  (sprite_desc),
		.sprite_valid (sprite_valid),
		.sprite_ready (sprite_ready)
	);

endmodule

//--- tests/fighter_anim_assertions.sv
`timescale 1ns/1ps

module fighter_anim_assertions
	import anim_pkg::*;
	import sprite_pkg::*;
#(
	parameter logic [X_W-1:0] X_MIN = X_W'(0),
	parameter logic [X_W-1:0] X_MAX = X_W'(600)
)
(
	input logic           Clk,
	input logic           rst_n,
	input logic           sprite_valid,
	input logic           sprite_ready,
	input logic           tick,
	input logic           restart,
	input pose_e          pose,
	input logic [X_W-1:0] x
);

	// a waiting descriptor may be replaced but never dropped
	valid_held: assert property (@(posedge Clk) disable iff (!rst_n)
		sprite_valid && !sprite_ready |=> sprite_valid)
		else $error("sprite_valid fell while sprite_ready was low");

	tick_one_cycle: assert property (@(posedge Clk) disable iff (!rst_n)
		tick |=> !tick)
		else $error("tick lasted more than one cycle");

	// restart belongs to a tick that really changes the pose
	restart_on_tick: assert property (@(posedge Clk) disable iff (!rst_n)
		restart |-> tick ##1 (pose != $past(pose)))
		else $error("restart seen outside a tick or without a pose change");

	x_in_bounds: assert property (@(posedge Clk) disable iff (!rst_n)
		(x >= X_MIN) && (x <= X_MAX))
		else $error("x left the arena bounds");

endmodule

bind fighter_anim_top fighter_anim_assertions #(
	.X_MIN (X_MIN),
	.X_MAX (X_MAX)
) i_assertions (
	.Clk          (Clk),
	.rst_n        (rst_n),
	.sprite_valid (sprite_valid),
	.sprite_ready (sprite_ready),
	.tick         (status.tick),
	.restart      (restart),
	.pose         (pose),
	.x            (x)
);

//--- tests/tb_fighter_anim.sv
`timescale 1ns/1ps

module tb_fighter_anim
	import anim_pkg::*;
	import sprite_pkg::*;
();

	localparam int X_LO = 0;
	localparam int X_HI = 600;
	localparam int X_INIT = 300;
	localparam int X_STEP = 4;

	localparam cmd_t CMD_NONE = 5'b00000;
	localparam cmd_t CMD_MR   = 5'b10000;
	localparam cmd_t CMD_ML   = 5'b01000;
	localparam cmd_t CMD_ATK  = 5'b00100;
	localparam cmd_t CMD_DEF  = 5'b00010;
	localparam cmd_t CMD_HURT = 5'b00001;

	typedef struct packed {
		cmd_t        cmd;
		logic [15:0] strobes;
		logic        stall;
		pose_e       pose;
		logic [7:0]  frame;
		logic [9:0]  x;
	} row_t;

	logic         Clk;
	logic         rst_n;
	logic         frame_clk;
	cmd_t         cmd;
	sprite_desc_t sprite_desc;
	logic         sprite_valid;
	logic         sprite_ready;

	row_t         table_q[$];
	sprite_desc_t accepted[$];
	int           cycle_count = 0;
	int           cycle_limit = 0;

	// reference model state
	pose_e m_pose;
	int    m_delay;
	int    m_frame;
	int    m_x;

	fighter_anim_top i_dut (
		.Clk          (Clk),
		.rst_n        (rst_n),
		.frame_clk    (frame_clk),
		.cmd          (cmd),
		.sprite_desc  (sprite_desc),
		.sprite_valid (sprite_valid),
		.sprite_ready (sprite_ready)
	);

	always #2 Clk = ~Clk;

	always @(posedge Clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	// every handshake, in order
	always @(posedge Clk)
	begin
		if (rst_n && sprite_valid && sprite_ready)
			accepted.push_back(sprite_desc);
	end

	function automatic int hold_strobes(pose_e p);
		return (p == pose_attack) ? 3 : 10;
	endfunction

	function automatic int last_frame_of(pose_e p);
		case (p)
			pose_stand:   return 7;
			pose_attack:  return 5;
			pose_move_l:  return 9;
			pose_move_r:  return 8;
			pose_defense: return 0;
			default:      return 4;
		endcase
	endfunction

	function automatic pose_e next_pose_of(pose_e p, cmd_t c, bit wrap);
		if (p == pose_attack || p == pose_defense || p == pose_hurt)
			return wrap ? pose_stand : p;
		// a held walk key keeps the walk
		if ((p == pose_move_r && c.move_r) || (p == pose_move_l && c.move_l))
			return p;
		if (c.attack)
			return pose_attack;
		if (c.move_r)
			return pose_move_r;
		if (c.move_l)
			return pose_move_l;
		if (c.defense)
			return pose_defense;
		if (c.hurt)
			return pose_hurt;
		return pose_stand;
	endfunction

	function automatic void add_row(cmd_t c, int n, bit stall, pose_e p, int f, int x_pos);
		row_t r;
		r.cmd = c;
		r.strobes = 16'(n);
		r.stall = stall;
		r.pose = p;
		r.frame = 8'(f);
		r.x = 10'(x_pos);
		table_q.push_back(r);
	endfunction

	task automatic advance_model(cmd_t c);
		pose_e np;
		bit    wrap;
		wrap = (m_delay >= hold_strobes(m_pose)) && (m_frame >= last_frame_of(m_pose));
		np = next_pose_of(m_pose, c, wrap);
		// x moves with the pose held before the strobe
		if (m_pose == pose_move_r)
			m_x = (m_x + X_STEP > X_HI) ? X_HI : m_x + X_STEP;
		else if (m_pose == pose_move_l)
			m_x = (m_x - X_STEP < X_LO) ? X_LO : m_x - X_STEP;
		if (np != m_pose)
		begin
			m_delay = 0;
			m_frame = 0;
		end
		else if (m_delay < hold_strobes(m_pose))
			m_delay++;
		else
		begin
			m_delay = 0;
			m_frame = (m_frame == last_frame_of(m_pose)) ? 0 : m_frame + 1;
		end
		m_pose = np;
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
		begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic compare_desc(sprite_desc_t d);
		check_value("sprite_desc.pose", 32'(d.pose), 32'(m_pose));
		check_value("sprite_desc.frame", 32'(d.frame), 32'(m_frame));
		check_value("sprite_desc.addr", 32'(d.addr), 32'(int'(m_pose) * 16 + m_frame));
		check_value("sprite_desc.x", 32'(d.x), 32'(m_x));
	endtask

	task automatic send_strobe();
		frame_clk <= 1'b1;
		repeat (4) @(posedge Clk);
		frame_clk <= 1'b0;
		repeat (4) @(posedge Clk);
	endtask

	task automatic wait_accept(output sprite_desc_t d);
		while (accepted.size() == 0)
			@(posedge Clk);
		d = accepted.pop_front();
	endtask

	initial
	begin
		row_t         row;
		sprite_desc_t last_d;
		int           stall_len;
		int           total;
		int           s;
		Clk = 1'b0;
		rst_n = 1'b0;
		frame_clk = 1'b0;
		cmd = CMD_NONE;
		sprite_ready = 1'b1;
		void'($urandom(32'h2772abdf));
		total = 0;

		// idle stand wraps frame 7 to 0 at strobe 88
		add_row(CMD_NONE, 90, 0, pose_stand, 0, 300);
		// walk right into the right bound, then left down to 0
		add_row(CMD_MR, 100, 0, pose_move_r, 0, 600);
		add_row(CMD_ML, 160, 0, pose_move_l, 4, 0);
		add_row(CMD_NONE, 3, 0, pose_stand, 0, 0);
		// attack beats move_r and plays out under move_l
		add_row(CMD_ATK | CMD_MR, 1, 0, pose_attack, 0, 0);
		add_row(CMD_ML, 24, 0, pose_stand, 0, 0);
		add_row(CMD_MR | CMD_DEF, 5, 0, pose_move_r, 0, 16);
		add_row(CMD_NONE, 1, 0, pose_stand, 0, 20);
		add_row(CMD_DEF, 12, 0, pose_stand, 0, 20);
		// stall on the last strobes of a walk
		add_row(CMD_MR, 6, 1, pose_move_r, 0, 40);
		add_row(CMD_HURT, 56, 0, pose_stand, 0, 44);
		add_row(CMD_NONE, 2, 0, pose_stand, 0, 44);

		foreach (table_q[i])
			total += int'(table_q[i].strobes);
		cycle_limit = total * 8 + 100;

		m_pose = pose_stand;
		m_delay = 0;
		m_frame = 0;
		m_x = X_INIT;
		repeat (5) @(posedge Clk);
		rst_n <= 1'b1;
		@(posedge Clk);

		foreach (table_q[r])
		begin
			row = table_q[r];
			cmd <= row.cmd;
			stall_len = row.stall ? 2 + int'($urandom % 2) : 0;
			for (s = 0; s < int'(row.strobes); s++)
			begin
				if (s == int'(row.strobes) - stall_len)
					sprite_ready <= 1'b0;
				send_strobe();
				advance_model(row.cmd);
				if (stall_len > 0 && s >= int'(row.strobes) - stall_len)
					check_value("accepted count during stall", accepted.size(), 0);
				else
				begin
					wait_accept(last_d);
					compare_desc(last_d);
				end
			end
			if (stall_len > 0)
			begin
				sprite_ready <= 1'b1;
				wait_accept(last_d);
				compare_desc(last_d);
				repeat (3) @(posedge Clk);
				check_value("accepted count after stall", accepted.size(), 0);
				check_value("sprite_valid", 32'(sprite_valid), 0);
			end
			check_value("row end pose", 32'(last_d.pose), 32'(row.pose));
			check_value("row end frame", 32'(last_d.frame), 32'(row.frame));
			check_value("row end x", 32'(last_d.x), 32'(row.x));
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- src.f
design/anim_pkg.sv
design/sprite_pkg.sv
design/anim_fsm.sv
design/frame_sequencer.sv
design/position_tracker.sv
design/sprite_output.sv
design/fighter_anim_top.sv
tests/fighter_anim_assertions.sv
tests/tb_fighter_anim.sv

//--- Bender.yml
package:
  name: fighter_anim

sources:
  - files:
      - design/anim_pkg.sv
      - design/sprite_pkg.sv
      - design/anim_fsm.sv
      - design/frame_sequencer.sv
      - design/position_tracker.sv
      - design/sprite_output.sv
      - design/fighter_anim_top.sv
  - target: test
    files:
      - tests/fighter_anim_assertions.sv
      - tests/tb_fighter_anim.sv
